//--- hdl/eeprom_bus_pkg.sv
package eeprom_bus_pkg;

    // fixed upper nibble of every control byte
    localparam logic [3:0] device_code = 4'b1010;

    // control bit 0 set means read
    localparam logic rw_bit_read = 1'b1;

    // block select field inside the control byte
    localparam int block_lsb = 1;
    localparam int block_msb = 3;

    typedef enum logic [2:0] {
        idle,
        ctrl,
        addr,
        data,
        rd_wait,
        rd_ctrl,
        rd_out
    } dec_state_t;

endpackage

//--- hdl/eeprom_mem_pkg.sv
package eeprom_mem_pkg;

    localparam int byte_width = 8;
    localparam int block_bits = 3;

    // block bits on top of the address byte
    localparam int mem_addr_width = block_bits + byte_width;

    localparam int mem_depth = 2048;

endpackage

//--- hdl/bus_sampler.sv
module bus_sampler #(
    parameter int sync_depth = 2
) (
    input  logic scl,
    input  logic rst,
    input  logic bus_clk,
    input  logic bus_data,
    output logic start_det,
    output logic stop_det,
    output logic clk_rise,
    output logic clk_fall,
    output logic data_bit
);

    logic [sync_depth-1:0] clk_sync;
    logic [sync_depth-1:0] data_sync;
    logic                  clk_now;
    logic                  data_now;
    logic                  clk_prev;
    logic                  data_prev;

    assign clk_now  = clk_sync[sync_depth-1];
    assign data_now = data_sync[sync_depth-1];

    always_ff @(posedge scl)
    begin
        if (rst)
        begin
            // idle bus is high on both lines
            clk_sync  <= '1;
            data_sync <= '1;
            clk_prev  <= 1'b1;
            data_prev <= 1'b1;
            start_det <= 1'b0;
            stop_det  <= 1'b0;
            clk_rise  <= 1'b0;
            clk_fall  <= 1'b0;
            data_bit  <= 1'b1;
        end
        else
        begin
            clk_sync  <= {clk_sync[sync_depth-2:0], bus_clk};
            data_sync <= {data_sync[sync_depth-2:0], bus_data};
            clk_prev  <= clk_now;
            data_prev <= data_now;
            // data moving while the clock stays high
            start_det <= clk_prev & clk_now & data_prev & ~data_now;
            stop_det  <= clk_prev & clk_now & ~data_prev & data_now;
            clk_rise  <= ~clk_prev & clk_now;
            clk_fall  <= clk_prev & ~clk_now;
            data_bit  <= data_now;
        end
    end

endmodule

//--- hdl/byte_shifter.sv
module byte_shifter import eeprom_mem_pkg::*; (
    input  logic                  scl,
    input  logic                  rst,
    input  logic                  clk_rise,
    input  logic                  data_bit,
    input  logic                  start_det,
    input  logic                  stop_det,
    output logic                  byte_valid,
    output logic [byte_width-1:0] byte_data
);

    logic [2:0] bit_cnt;

    always_ff @(posedge scl)
    begin
        if (rst)
        begin
            bit_cnt    <= '0;
            byte_valid <= 1'b0;
        end
        else
        begin
            byte_valid <= 1'b0;
            // bus conditions realign the byte boundary
            if (start_det || stop_det)
            begin
                bit_cnt <= '0;
            end
            else if (clk_rise)
            begin
                bit_cnt    <= bit_cnt + 3'd1;
                byte_valid <= (bit_cnt == 3'd7);
            end
        end
    end

    // msb first; bytes seen during read-out are dropped by the decoder
    always_ff @(posedge scl)
    begin
        if (clk_rise)
        begin
            byte_data <= {byte_data[byte_width-2:0], data_bit};
        end
    end

endmodule

//--- hdl/command_decoder.sv
module command_decoder import eeprom_bus_pkg::*, eeprom_mem_pkg::*; (
    input  logic                      scl,
    input  logic                      rst,
    input  logic                      byte_valid,
    input  logic [byte_width-1:0]     byte_data,
    input  logic                      start_det,
    input  logic                      stop_det,
    output logic                      wr_en,
    output logic [mem_addr_width-1:0] wr_addr,
    output logic [byte_width-1:0]     wr_data,
    output logic                      rd_en,
    output logic [mem_addr_width-1:0] rd_addr,
    output logic                      load
);

    dec_state_t            state;
    logic [block_bits-1:0] block_reg;
    logic [byte_width-1:0] addr_reg;
    logic                  code_ok;

    assign code_ok = (byte_data[7:4] == device_code);

    // both ports see the address latched by the write control and address bytes
    assign wr_addr = {block_reg, addr_reg};
    assign rd_addr = {block_reg, addr_reg};

    always_ff @(posedge scl)
    begin
        if (rst)
        begin
            state <= idle;
            wr_en <= 1'b0;
            rd_en <= 1'b0;
            load  <= 1'b0;
        end
        else
        begin
            wr_en <= 1'b0;
            rd_en <= 1'b0;
            load  <= 1'b0;
            if (stop_det)
            begin
                state <= idle;
            end
            else if (start_det)
            begin
                // repeated start after the address turns into a read
                state <= (state == data) ? rd_ctrl : ctrl;
            end
            else
            begin
                case (state)
                    ctrl:
                    begin
                        if (byte_valid)
                        begin
                            if (code_ok && byte_data[0] != rw_bit_read)
                                state <= addr;
                            else
                                state <= idle;
                        end
                    end
                    addr:
                    begin
                        if (byte_valid)
                            state <= data;
                    end
                    data:
                    begin
                        if (byte_valid)
                        begin
                            wr_en <= 1'b1;
                            state <= idle;
                        end
                    end
                    rd_ctrl:
                    begin
                        if (byte_valid)
                        begin
                            if (code_ok && byte_data[0] == rw_bit_read)
                            begin
                                rd_en <= 1'b1;
                                state <= rd_wait;
                            end
                            else
                            begin
                                state <= idle;
                            end
                        end
                    end
                    rd_wait:
                    begin
                        // rd_data lands this cycle
                        load  <= 1'b1;
                        state <= rd_out;
                    end
                    default:
                    begin
                        // idle and rd_out only leave on start or stop
                        state <= state;
                    end
                endcase
            end
        end
    end

    always_ff @(posedge scl)
    begin
        if (byte_valid && state == ctrl)
            block_reg <= byte_data[block_msb:block_lsb];
        if (byte_valid && state == addr)
            addr_reg <= byte_data;
        if (byte_valid && state == data)
            wr_data <= byte_data;
    end

endmodule

//--- hdl/memory_array.sv
module memory_array import eeprom_mem_pkg::*; (
    input  logic                      scl,
    input  logic                      wr_en,
    input  logic [mem_addr_width-1:0] wr_addr,
    input  logic [byte_width-1:0]     wr_data,
    input  logic                      rd_en,
    input  logic [mem_addr_width-1:0] rd_addr,
    output logic [byte_width-1:0]     rd_data
);

    logic [byte_width-1:0] mem [mem_depth];

    always_ff @(posedge scl)
    begin
        if (wr_en)
        begin
            mem[wr_addr] <= wr_data;
        end
    end

    // registered read, one cycle after rd_en
    always_ff @(posedge scl)
    begin
        if (rd_en)
        begin
            rd_data <= mem[rd_addr];
        end
    end

endmodule

//--- hdl/read_serializer.sv
module read_serializer import eeprom_mem_pkg::*; (
    input  logic                  scl,
    input  logic                  rst,
    input  logic                  load,
    input  logic [byte_width-1:0] rd_data,
    input  logic                  clk_fall,
    input  logic                  start_det,
    input  logic                  stop_det,
    output logic                  sda_out,
    output logic                  sda_oe
);

    logic [byte_width-1:0] shift_reg;
    logic [3:0]            bit_cnt;

    always_ff @(posedge scl)
    begin
        if (rst)
        begin
            sda_oe  <= 1'b0;
            sda_out <= 1'b1;
            bit_cnt <= '0;
        end
        else if (start_det || stop_det)
        begin
            sda_oe <= 1'b0;
        end
        else if (load)
        begin
            // msb goes out at once, ahead of the next rising bus clock
            shift_reg <= rd_data;
            sda_out   <= rd_data[byte_width-1];
            bit_cnt   <= '0;
            sda_oe    <= 1'b1;
        end
        else if (clk_fall && sda_oe)
        begin
            if (bit_cnt == 4'(byte_width))
            begin
                sda_oe <= 1'b0;
            end
            else
            begin
                sda_out   <= shift_reg[byte_width-1];
                shift_reg <= {shift_reg[byte_width-2:0], 1'b0};
                bit_cnt   <= bit_cnt + 4'd1;
            end
        end
    end

endmodule

//--- hdl/serial_eeprom.sv
module serial_eeprom import eeprom_mem_pkg::*; #(
    parameter int sync_depth = 2
) (
    input  logic scl,
    input  logic rst,
    input  logic bus_clk,
    input  logic bus_data,
    output logic sda_out,
    output logic sda_oe
);

    logic                      start_det;
    logic                      stop_det;
    logic                      clk_rise;
    logic                      clk_fall;
    logic                      data_bit;
    logic                      byte_valid;
    logic [byte_width-1:0]     byte_data;
    logic                      wr_en;
    logic [mem_addr_width-1:0] wr_addr;
    logic [byte_width-1:0]     wr_data;
    logic                      rd_en;
    logic [mem_addr_width-1:0] rd_addr;
    logic [byte_width-1:0]     rd_data;
    logic                      load;

    bus_sampler #(
        .sync_depth (sync_depth)
    ) bus_sampler_inst (
        .scl       (scl),
        .rst       (rst),
        .bus_clk   (bus_clk),
        .bus_data  (bus_data),
        .start_det (start_det),
        .stop_det  (stop_det),
        .clk_rise  (clk_rise),
        .clk_fall  (clk_fall),
        .data_bit  (data_bit)
    );

    byte_shifter byte_shifter_inst (
        .scl        (scl),
        .rst        (rst),
        .clk_rise   (clk_rise),
        .data_bit   (data_bit),
        .start_det  (start_det),
        .stop_det   (stop_det),
        .byte_valid (byte_valid),
        .byte_data  (byte_data)
    );

    command_decoder command_decoder_inst (
        .scl        (scl),
        .rst        (rst),
        .byte_valid (byte_valid),
        .byte_data  (byte_data),
        .start_det  (start_det),
        .stop_det   (stop_det),
        .wr_en      (wr_en),
        .wr_addr    (wr_addr),
        .wr_data    (wr_data),
        .rd_en      (rd_en),
        .rd_addr    (rd_addr),
        .load       (load)
    );

    memory_array memory_array_inst (
        .scl     (scl),
        .wr_en   (wr_en),
        .wr_addr (wr_addr),
        .wr_data (wr_data),
        .rd_en   (rd_en),
        .rd_addr (rd_addr),
        .rd_data (rd_data)
    );

    read_serializer read_serializer_inst (
        .scl       (scl),
        .rst       (rst),
        .load      (load),
        .rd_data   (rd_data),
        .clk_fall  (clk_fall),
        .start_det (start_det),
        .stop_det  (stop_det),
        .sda_out   (sda_out),
        .sda_oe    (sda_oe)
    );

endmodule

//--- test/serial_eeprom_tb.sv
module serial_eeprom_tb import eeprom_bus_pkg::*, eeprom_mem_pkg::*; ();

    localparam int quarter_cycles = 8;
    // a random read is the longest transfer at about 35 bus bits
    localparam int bits_per_trans = 40;
    localparam logic [8:0] from_random = 9'h100;

    logic scl;
    logic rst;
    logic bus_clk;
    logic bus_data;
    logic sda_out;
    logic sda_oe;

    string      op_q[$];
    logic [3:0] nib_q[$];
    logic [2:0] blk_q[$];
    logic [7:0] ofs_q[$];
    logic [8:0] data_q[$];
    logic [8:0] exp_q[$];
    logic [7:0] ref_mem [mem_depth];

    int seed = 32'h33f1b94c;
    int check_count = 0;
    int mismatches = 0;
    int other_errors = 0;
    int cycle_cnt = 0;
    int cycle_limit = 200;

    serial_eeprom #(
        .sync_depth (2)
    ) serial_eeprom_inst (
        .scl      (scl),
        .rst      (rst),
        .bus_clk  (bus_clk),
        .bus_data (bus_data),
        .sda_out  (sda_out),
        .sda_oe   (sda_oe)
    );

    initial
    begin
        scl = 1'b0;
        forever #5 scl = ~scl;
    end

    always @(posedge scl)
    begin
        cycle_cnt = cycle_cnt + 1;
        if (cycle_cnt > cycle_limit)
        begin
            $display("ERROR: timeout after %0d cycles, the bus transfers never finished",
                     cycle_cnt);
            other_errors = other_errors + 1;
            print_counts();
            $display("TEST FAIL");
            $finish;
        end
    end

    task automatic print_counts();
        $display("checks %0d, mismatches %0d, other errors %0d",
                 check_count, mismatches, other_errors);
    endtask

    task automatic check_value(input string name, input logic [7:0] expected,
                               input logic [7:0] actual);
        check_count = check_count + 1;
        if (actual !== expected)
        begin
            $display("FAIL %s expected %02h actual %02h", name, expected, actual);
            mismatches = mismatches + 1;
        end
    endtask

    task automatic wait_quarter();
        repeat (quarter_cycles) @(negedge scl);
    endtask

    // data set while the clock is low, slave output must stay off
    task automatic send_bit(input logic b, input string name);
        bus_data = b;
        wait_quarter();
        check_value({name, " sda_oe"}, 8'h00, {7'd0, sda_oe});
        bus_clk = 1'b1;
        wait_quarter();
        wait_quarter();
        bus_clk = 1'b0;
        wait_quarter();
    endtask

    task automatic send_byte(input logic [7:0] value, input string name);
        for (int i = 7; i >= 0; i--)
            send_bit(value[i], name);
    endtask

    task automatic send_start();
        bus_data = 1'b1;
        wait_quarter();
        bus_clk = 1'b1;
        wait_quarter();
        bus_data = 1'b0;
        wait_quarter();
        bus_clk = 1'b0;
        wait_quarter();
    endtask

    task automatic send_stop(input string name);
        bus_data = 1'b0;
        wait_quarter();
        bus_clk = 1'b1;
        wait_quarter();
        bus_data = 1'b1;
        wait_quarter();
        wait_quarter();
        check_value({name, " sda_oe after stop"}, 8'h00, {7'd0, sda_oe});
    endtask

    // master releases the line; sampled level is the open-drain wire
    task automatic read_byte(input string name, output logic [7:0] value);
        for (int i = 7; i >= 0; i--)
        begin
            bus_data = 1'b1;
            wait_quarter();
            bus_clk = 1'b1;
            wait_quarter();
            check_value({name, " sda_oe"}, 8'h01, {7'd0, sda_oe});
            value[i] = sda_oe ? sda_out : 1'b1;
            wait_quarter();
            bus_clk = 1'b0;
            wait_quarter();
        end
        check_value({name, " sda_oe after byte"}, 8'h00, {7'd0, sda_oe});
    endtask

    task automatic do_write(input logic [3:0] nibble, input logic [2:0] blk,
                            input logic [7:0] ofs, input logic [7:0] value, input string name);
        send_start();
        send_byte({nibble, blk, 1'b0}, name);
        send_byte(ofs, name);
        send_byte(value, name);
        send_stop(name);
    endtask

    // stop lands halfway through the data byte
    task automatic do_abort(input logic [3:0] nibble, input logic [2:0] blk,
                            input logic [7:0] ofs, input logic [7:0] value, input string name);
        send_start();
        send_byte({nibble, blk, 1'b0}, name);
        send_byte(ofs, name);
        for (int i = 7; i >= 4; i--)
            send_bit(value[i], name);
        send_stop(name);
    endtask

    task automatic do_read(input logic [3:0] nibble, input logic [2:0] blk,
                           input logic [7:0] ofs, input string name, output logic [7:0] value);
        send_start();
        send_byte({nibble, blk, 1'b0}, name);
        send_byte(ofs, name);
        send_start();
        send_byte({nibble, blk, rw_bit_read}, name);
        read_byte(name, value);
        send_stop(name);
    endtask

    task automatic load_stimulus();
        int         fd;
        int         n;
        string      line;
        string      f_op;
        logic [3:0] f_nib;
        logic [2:0] f_blk;
        logic [7:0] f_ofs;
        logic [8:0] f_data;
        logic [8:0] f_exp;
        fd = $fopen("test/serial_eeprom_stim.txt", "r");
        if (fd == 0)
        begin
            $display("ERROR: cannot open the stimulus file test/serial_eeprom_stim.txt");
            other_errors = other_errors + 1;
            return;
        end
        while ($fgets(line, fd) != 0)
        begin
            if (line.len() < 2 || line.getc(0) == "#")
                continue;
            n = $sscanf(line, "%s %h %h %h %h %h", f_op, f_nib, f_blk, f_ofs, f_data, f_exp);
            if (n != 6)
            begin
                $display("ERROR: stimulus line cannot be parsed: %s", line);
                other_errors = other_errors + 1;
            end
            else
            begin
                op_q.push_back(f_op);
                nib_q.push_back(f_nib);
                blk_q.push_back(f_blk);
                ofs_q.push_back(f_ofs);
                data_q.push_back(f_data);
                exp_q.push_back(f_exp);
            end
        end
        $fclose(fd);
    endtask

    initial
    begin
        string                     name;
        string                     op;
        logic [7:0]                wdata;
        logic [7:0]                rdata;
        logic [7:0]                expected;
        logic [31:0]               rnd;
        logic [mem_addr_width-1:0] full_addr;

        rst = 1'b1;
        bus_clk = 1'b1;
        bus_data = 1'b1;
        load_stimulus();
        if (op_q.size() == 0)
        begin
            $display("ERROR: the stimulus file holds no transactions");
            other_errors = other_errors + 1;
        end
        cycle_limit = op_q.size() * bits_per_trans * 32 + 200;
        repeat (2) @(negedge scl);
        rst = 1'b0;
        wait_quarter();

        for (int idx = 0; idx < op_q.size(); idx++)
        begin
            op = op_q[idx];
            full_addr = {blk_q[idx], ofs_q[idx]};
            name = $sformatf("#%0d %s block %0d addr %02h", idx, op, blk_q[idx], ofs_q[idx]);
            if (op == "w")
            begin
                if (data_q[idx] == from_random)
                begin
                    rnd = $random(seed);
                    wdata = rnd[7:0];
                end
                else
                begin
                    wdata = data_q[idx][7:0];
                end
                do_write(nib_q[idx], blk_q[idx], ofs_q[idx], wdata, name);
                // a foreign device code must leave memory alone
                if (nib_q[idx] == device_code)
                    ref_mem[full_addr] = wdata;
            end
            else if (op == "a")
            begin
                do_abort(nib_q[idx], blk_q[idx], ofs_q[idx], data_q[idx][7:0], name);
            end
            else if (op == "r")
            begin
                do_read(nib_q[idx], blk_q[idx], ofs_q[idx], name, rdata);
                if (exp_q[idx] == from_random)
                    expected = ref_mem[full_addr];
                else
                    expected = exp_q[idx][7:0];
                check_value(name, expected, rdata);
            end
            else
            begin
                $display("ERROR: unknown operation %s in transaction %0d", op, idx);
                other_errors = other_errors + 1;
            end
        end

        print_counts();
        if (mismatches == 0 && other_errors == 0)
            $display("TEST PASS");
        else
            $display("TEST FAIL");
        $finish;
    end

endmodule

//--- flist.f
hdl/eeprom_bus_pkg.sv
hdl/eeprom_mem_pkg.sv
hdl/bus_sampler.sv
hdl/byte_shifter.sv
hdl/command_decoder.sv
hdl/memory_array.sv
hdl/read_serializer.sv
hdl/serial_eeprom.sv
test/serial_eeprom_tb.sv

//--- run.sh
#!/bin/sh
# builds and runs the serial EEPROM testbench with Verilator

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir
if [ $? -ne 0 ]; then
    echo "could not remove the old build directory"
    exit 1
fi

verilator --binary -f flist.f --top-module serial_eeprom_tb -o serial_eeprom_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/serial_eeprom_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -qx "TEST PASS" sim.log; then
    exit 0
fi
echo "pass message not found in sim.log"
exit 1

//--- test/serial_eeprom_stim.txt
# op nibble block addr data expected, all hex; op w is a write, r a read, a an aborted write
# data 100 writes a $random byte, expected 100 compares with the reference memory
w a 0 3c 11 00
w a 1 3c 22 00
w a 2 3c 33 00
w a 3 3c 44 00
w a 4 3c 55 00
w a 5 3c 66 00
w a 6 3c 77 00
w a 7 3c 88 00
r a 0 3c 00 11
r a 5 3c 00 66
r a 1 3c 00 22
r a 7 3c 00 88
r a 3 3c 00 44
r a 4 3c 00 55
r a 2 3c 00 33
r a 6 3c 00 77
w 5 2 3c ee 00
r a 2 3c 00 33
a a 6 3c 99 00
r a 6 3c 00 77
w a 1 07 100 00
w a 4 e2 100 00
w a 7 81 100 00
w a 3 5f 100 00
r a 7 81 00 100
r a 3 5f 00 100
r a 1 07 00 100
r a 4 e2 00 100
